// ==== sim/lock_vectors.txt ====
# name op value display tries state (0 entry, 1 open, 2 lockout), all values hex except tries, state
# value is a key pattern, or three digits for the digits and try ops
reset expect 0 fff 0 0
open_digits digits 246 246 0 0
open_enter press 0001 bcc 0 1
open_buzz buzz 0 bcc 0 1
open_master press 0100 fff 0 0
four_digits digits 135 135 0 0
four_extra press 8000 135 0 0
wrong_enter press 0001 fff 1 0
wrong_buzz buzz 0 fff 1 0
clear_digits digits 111 111 1 0
clear_key press 1000 fff 1 0
lock_try2 try 999 fff 2 0
lock_try3 try 999 fff 3 0
lock_try4 try 999 000 4 2
lock_digit press 0040 000 4 2
lock_count until 0 006 4 2
lock_end until 0 fff 0 0
relock_1 try 999 fff 1 0
relock_2 try 999 fff 2 0
relock_3 try 999 fff 3 0
relock_4 try 999 000 4 2
relock_master press 0100 fff 0 0
hold_first hold 0040 ff2 0 0
hold_same hold 0040 ff2 0 0
hold_unused hold 0002 ff2 0 0
hold_release release 0 ff2 0 0

// ==== list.f ====
+incdir+verilog
verilog/lock_pkg.sv
verilog/key_decoder.sv
verilog/code_checker.sv
verilog/tone_channel.sv
verilog/buzzer_mixer.sv
verilog/lock_top.sv
sim/lock_asserts.sv
sim/lock_tb.sv

// ==== sim/lock_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module lock_tb;
    import lock_pkg::*;

    localparam int wait_limit = 1000;   // cycles per wait loop

    logic        clk = 1'b0;
    logic        rst_n;
    logic [15:0] keys;
    display_t    display;
    tries_t      tries;
    lock_state_t state;
    logic        buzzer;

    // keypad pattern of each digit
    logic [15:0] digit_keys [10] = '{`LOCK_KEY_0, `LOCK_KEY_1, `LOCK_KEY_2, `LOCK_KEY_3,
        `LOCK_KEY_4, `LOCK_KEY_5, `LOCK_KEY_6, `LOCK_KEY_7, `LOCK_KEY_8, `LOCK_KEY_9};

    lock_top i_dut (.clk(clk), .rst_n(rst_n), .keys(keys), .display(display),
                    .tries(tries), .state(state), .buzzer(buzzer));

    always #20 clk = ~clk;

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;   // inputs change just after the edge
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input string what,
                         input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            stop_run($sformatf("MISMATCH %s %s expected %h actual %h", name, what, exp, act));
        end
    endtask

    task automatic compare_outputs(input string name, input logic [11:0] disp,
                                   input int t, input int s);
        check(name, "display", 16'(disp), 16'(display));
        check(name, "tries", 16'(t), 16'(tries));
        check(name, "state", 16'(s), 16'(state));
    endtask

    task automatic drive(input logic [15:0] pattern);
        keys = pattern;
        step(4);
    endtask

    task automatic tap(input logic [15:0] pattern);
        drive(pattern);
        drive('0);   // release between presses
    endtask

    // high nibble is the first digit pressed
    task automatic enter_digits(input logic [11:0] digits);
        for (int i = 2; i >= 0; i--) begin
            tap(digit_keys[digits[4*i +: 4]]);
        end
    endtask

    task automatic wait_buzzer(input string name, input logic level);
        int n;
        n = 0;
        while (buzzer !== level) begin
            if (n == wait_limit) begin
                stop_run($sformatf("%s: buzzer did not go to %0b in time", name, level));
            end
            step(1);
            n++;
        end
    endtask

    task automatic wait_outputs(input string name, input logic [11:0] disp,
                                input int t, input int s);
        int n;
        n = 0;
        while (display !== disp || tries !== t || state !== s) begin
            if (n == wait_limit) begin
                stop_run($sformatf("%s: outputs did not settle to the expected values", name));
            end
            step(1);
            n++;
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        string       name;
        string       op;
        logic [15:0] value;
        logic [11:0] disp;
        int          t;
        int          s;
        rst_n = 1'b0;
        keys  = '0;
        fd = $fopen("sim/lock_vectors.txt", "r");
        if (fd == 0) begin
            stop_run("could not open sim/lock_vectors.txt");
        end
        step(16);
        rst_n = 1'b1;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            code = $sscanf(line, "%s %s %h %h %d %d", name, op, value, disp, t, s);
            if (code != 6) begin
                stop_run({"malformed vector line: ", line});
            end
            if (op == "press") begin
                tap(value);
            end else if (op == "hold") begin
                drive(value);   // no release, key stays down
            end else if (op == "release") begin
                drive('0);
            end else if (op == "digits") begin
                enter_digits(value[11:0]);
            end else if (op == "try") begin
                enter_digits(value[11:0]);
                tap(`LOCK_KEY_ENTER);
            end else if (op == "buzz") begin
                step(`LOCK_DUR_CLICK);   // key click has died out by now
                wait_buzzer(name, 1'b1);
                wait_buzzer(name, 1'b0);   // toggling, not stuck high
            end else if (op == "until") begin
                wait_outputs(name, disp, t, s);
            end else if (op != "expect") begin
                stop_run({"unknown vector op: ", op});
            end
            compare_outputs(name, disp, t, s);
        end
        $fclose(fd);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/lock_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module lock_asserts (
    input logic                clk,
    input logic                rst_n,
    input lock_pkg::display_t  display,
    input lock_pkg::tries_t    tries,
    input lock_pkg::tone_sel_t actives,
    input logic                buzzer
);
    import lock_pkg::*;

    a_reset_blank: assert property (@(posedge clk) !rst_n |=> display == 12'hFFF)
        else $error("display not blank during reset");

    a_tries_limit: assert property (@(posedge clk) disable iff (!rst_n)
        tries <= tries_t'(`LOCK_MAX_TRIES))
        else $error("tries above limit");

    // buzzer register lags the channels by one cycle
    a_quiet_buzzer: assert property (@(posedge clk) disable iff (!rst_n)
        $past(actives) == '0 |-> !buzzer)
        else $error("buzzer high with no active channel");

endmodule

bind lock_top lock_asserts i_asserts (.clk(clk), .rst_n(rst_n), .display(display),
                                      .tries(tries), .actives(actives), .buzzer(buzzer));

`default_nettype wire

// ==== verilog/lock_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module lock_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [15:0]           keys,
    output lock_pkg::display_t    display,
    output lock_pkg::tries_t      tries,
    output lock_pkg::lock_state_t state,
    output logic                  buzzer
);
    import lock_pkg::*;

    key_event_t key_evt;
    tone_sel_t  tone_start;
    tone_sel_t  tones;
    tone_sel_t  actives;

    key_decoder i_key_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .key_evt (key_evt)
    );

    code_checker i_code_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_evt    (key_evt),
        .display    (display),
        .tries      (tries),
        .state      (state),
        .tone_start (tone_start)
    );

    // channel 0 click, 1 success, 2 failure
    for (genvar i = 0; i < `LOCK_TONES; i++) begin : g_tone
        localparam int half = (i == 0) ? `LOCK_HALF_CLICK :
                              (i == 1) ? `LOCK_HALF_SUCCESS : `LOCK_HALF_FAIL;
        localparam int dur  = (i == 0) ? `LOCK_DUR_CLICK :
                              (i == 1) ? `LOCK_DUR_SUCCESS : `LOCK_DUR_FAIL;

        tone_channel #(
            .half_period (half),
            .duration    (dur)
        ) i_tone (
            .clk    (clk),
            .rst_n  (rst_n),
            .start  (tone_start[i]),
            .tone   (tones[i]),
            .active (actives[i])
        );
    end

    buzzer_mixer i_buzzer_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tone_start (tone_start),
        .tones      (tones),
        .actives    (actives),
        .buzzer     (buzzer)
    );

endmodule

`default_nettype wire

// ==== verilog/buzzer_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module buzzer_mixer (
    input  logic                clk,
    input  logic                rst_n,
    input  lock_pkg::tone_sel_t tone_start,
    input  lock_pkg::tone_sel_t tones,
    input  lock_pkg::tone_sel_t actives,
    output logic                buzzer
);
    localparam int n_ch  = $bits(tone_start);
    localparam int own_w = $clog2(n_ch);

    logic [own_w-1:0] owner;
    logic [own_w-1:0] start_idx;   // highest started channel

    always_comb begin
        start_idx = owner;
        for (int i = 0; i < n_ch; i++) begin
            if (tone_start[i]) begin
                start_idx = own_w'(i);   // later index overrides
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner  <= '0;
            buzzer <= 1'b0;
        end else begin
            owner  <= start_idx;
            buzzer <= actives[owner] & tones[owner];   // silent when owner idle
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tone_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tone_channel #(
    parameter int half_period = 2,
    parameter int duration    = 40
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic tone,
    output logic active
);
    localparam int dur_w  = $clog2(duration + 1);
    localparam int half_w = $clog2(half_period + 1);

    logic [dur_w-1:0]  dur_cnt;    // cycles spent active
    logic [half_w-1:0] half_cnt;   // cycles in current half period

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            tone     <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (start) begin
            active   <= 1'b1;   // restart even if already running
            tone     <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (dur_cnt == dur_w'(duration - 1)) begin
                active <= 1'b0;
                tone   <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt + 1'b1;
                if (half_cnt == half_w'(half_period - 1)) begin
                    half_cnt <= '0;
                    tone     <= ~tone;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/code_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module code_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lock_pkg::key_event_t  key_evt,
    output lock_pkg::display_t    display,
    output lock_pkg::tries_t      tries,
    output lock_pkg::lock_state_t state,
    output lock_pkg::tone_sel_t   tone_start
);
    import lock_pkg::*;

    localparam int tick_w = $clog2(`LOCK_TICK_CYCLES);
    localparam display_t blank = 12'hFFF;

    logic [1:0]        digit_cnt;   // digits entered so far
    logic [tick_w-1:0] tick_cnt;
    tries_t            tries_next;
    logic              tick;

    assign tries_next = tries + 3'd1;
    assign tick       = (tick_cnt == tick_w'(`LOCK_TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_entry;
            display    <= blank;
            tries      <= '0;
            digit_cnt  <= '0;
            tick_cnt   <= '0;
            tone_start <= '0;
        end else begin
            tone_start <= '0;   // single cycle start pulses
            if (key_evt.valid && key_evt.kind == key_master) begin
                state     <= st_entry;   // master wins in any state
                display   <= blank;
                tries     <= '0;
                digit_cnt <= '0;
            end else begin
                case (state)
                    st_entry: if (key_evt.valid) begin
                        case (key_evt.kind)
                            key_digit: if (digit_cnt < 2'd3) begin
                                display       <= {display[7:0], key_evt.digit};
                                digit_cnt     <= digit_cnt + 2'd1;
                                tone_start[0] <= 1'b1;
                            end
                            key_enter: if (digit_cnt == 2'd3) begin
                                if (display == `LOCK_SECRET) begin
                                    display       <= `LOCK_OPEN_SHOW;
                                    state         <= st_open;
                                    tone_start[1] <= 1'b1;
                                end else begin
                                    digit_cnt     <= '0;
                                    tries         <= tries_next;
                                    tone_start[2] <= 1'b1;
                                    if (tries_next == tries_t'(`LOCK_MAX_TRIES)) begin
                                        display  <= '0;   // lockout counter starts at 000
                                        state    <= st_lockout;
                                        tick_cnt <= '0;
                                    end else begin
                                        display <= blank;
                                    end
                                end
                            end
                            key_clear: begin
                                display   <= blank;   // tries kept
                                digit_cnt <= '0;
                            end
                            default: ;
                        endcase
                    end
                    st_open: if (key_evt.valid && key_evt.kind == key_clear) begin
                        state     <= st_entry;
                        display   <= blank;
                        digit_cnt <= '0;
                    end
                    st_lockout: begin
                        if (tick) begin
                            tick_cnt <= '0;
                            // final second has been shown, release the lock
                            if (display[3:0] == digit_t'(`LOCK_LOCKOUT_SECONDS)) begin
                                state     <= st_entry;
                                display   <= blank;
                                tries     <= '0;
                                digit_cnt <= '0;
                            end else begin
                                display[3:0] <= display[3:0] + 4'd1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    default: state <= st_entry;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/key_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lock_consts.svh"

module key_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [15:0]          keys,
    output lock_pkg::key_event_t key_evt
);
    import lock_pkg::*;

    logic [15:0] keys_q;
    logic [15:0] keys_prev;
    key_kind_t   kind;
    digit_t      digit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            keys_q    <= '0;
            keys_prev <= '0;
        end else begin
            keys_q    <= keys;
            keys_prev <= keys_q;   // invalid patterns are remembered too
        end
    end

    always_comb begin
        kind  = key_none;
        digit = 4'hF;
        case (keys_q)
            `LOCK_KEY_ENTER:  kind = key_enter;
            `LOCK_KEY_CLEAR:  kind = key_clear;
            `LOCK_KEY_MASTER: kind = key_master;
            `LOCK_KEY_0: begin kind = key_digit; digit = 4'd0; end
            `LOCK_KEY_1: begin kind = key_digit; digit = 4'd1; end
            `LOCK_KEY_2: begin kind = key_digit; digit = 4'd2; end
            `LOCK_KEY_3: begin kind = key_digit; digit = 4'd3; end
            `LOCK_KEY_4: begin kind = key_digit; digit = 4'd4; end
            `LOCK_KEY_5: begin kind = key_digit; digit = 4'd5; end
            `LOCK_KEY_6: begin kind = key_digit; digit = 4'd6; end
            `LOCK_KEY_7: begin kind = key_digit; digit = 4'd7; end
            `LOCK_KEY_8: begin kind = key_digit; digit = 4'd8; end
            `LOCK_KEY_9: begin kind = key_digit; digit = 4'd9; end
            default:     kind = key_none;   // zero, unused or not one hot
        endcase
    end

    // event only on a change to a used pattern
    assign key_evt = '{valid: (keys_q != keys_prev) && (kind != key_none),
                       kind:  kind,
                       digit: digit};

endmodule

`default_nettype wire

// ==== verilog/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    typedef logic [3:0] digit_t;      // bcd digit, 4'hF is blank
    typedef logic [11:0] display_t;   // three digits, newest lowest
    typedef logic [2:0] tries_t;      // failed attempt count
    typedef logic [2:0] tone_sel_t;   // bit 0 click, 1 success, 2 failure

    typedef enum logic [2:0] {
        key_none,
        key_digit,
        key_enter,
        key_clear,
        key_master
    } key_kind_t;

    // one decoded key press, valid for a single cycle
    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        digit_t    digit;
    } key_event_t;

    typedef enum logic [1:0] {
        st_entry,
        st_open,
        st_lockout
    } lock_state_t;

endpackage

`default_nettype wire

// ==== verilog/lock_consts.svh ====
`ifndef LOCK_CONSTS_SVH
`define LOCK_CONSTS_SVH

// keypad one-hot patterns
`define LOCK_KEY_ENTER  16'h0001
`define LOCK_KEY_MASTER 16'h0100
`define LOCK_KEY_CLEAR  16'h1000
`define LOCK_KEY_0      16'h0008
`define LOCK_KEY_1      16'h0080
`define LOCK_KEY_2      16'h0040
`define LOCK_KEY_3      16'h0020
`define LOCK_KEY_4      16'h0800
`define LOCK_KEY_5      16'h0400
`define LOCK_KEY_6      16'h0200
`define LOCK_KEY_7      16'h8000
`define LOCK_KEY_8      16'h4000
`define LOCK_KEY_9      16'h2000

`define LOCK_SECRET          12'h246
`define LOCK_OPEN_SHOW       12'hBCC   // shown while open
`define LOCK_MAX_TRIES       4
`define LOCK_TICK_CYCLES     50        // clocks per lockout second
`define LOCK_LOCKOUT_SECONDS 6

`define LOCK_TONES        3
`define LOCK_HALF_CLICK   2   // half periods in clocks
`define LOCK_HALF_SUCCESS 1
`define LOCK_HALF_FAIL    4
`define LOCK_DUR_CLICK    40  // durations in clocks
`define LOCK_DUR_SUCCESS  120
`define LOCK_DUR_FAIL     80

`endif
